// File: verilog.f
verilog/mem_map_pkg.sv
verilog/video_pkg.sv
verilog/bus_decode.sv
verilog/memory_block.sv
verilog/ms_timer.sv
verilog/system_control.sv
verilog/layer_mixer.sv
verilog/system.sv
bench/system_tb.sv

// File: Bender.yml
package:
  name: system

sources:
  - verilog/mem_map_pkg.sv
  - verilog/video_pkg.sv
  - verilog/bus_decode.sv
  - verilog/memory_block.sv
  - verilog/ms_timer.sv
  - verilog/system_control.sv
  - verilog/layer_mixer.sv
  - verilog/system.sv
  - target: simulation
    files:
      - bench/system_tb.sv

// File: bench/system_tb.sv
`timescale 1ns/1ps

module system_tb;

	localparam int TICKS = 8;
	// Stimulus runs well under half of this
	localparam int MAX_CYCLES = 5000;
	localparam logic [15:0] IDLE_ADDR = 16'h8F80;

	logic clk_24;
	logic rst;
	logic pause;
	logic menu;
	logic [15:0] cpu_addr;
	logic [7:0] cpu_dout;
	logic cpu_wr_n;
	logic [7:0] cpu_din;
	logic cpu_wait;
	logic [16:0] dn_addr;
	logic [7:0] dn_data;
	logic dn_wr;
	logic [7:0] dn_index;
	logic [191:0] joystick;
	logic [47:0] paddle;
	logic [32:0] timestamp;
	video_pkg::rgb_t char_rgb;
	video_pkg::rgb_t spr_rgb;
	video_pkg::rgb_t tile_rgb;
	logic char_a;
	logic spr_a;
	logic tile_a;
	logic sf_on1;
	logic sf_on2;
	logic sf_on3;
	logic [7:0] sf_star1;
	logic [7:0] sf_star2;
	logic [7:0] sf_star3;
	logic [7:0] vga_r;
	logic [7:0] vga_g;
	logic [7:0] vga_b;

	logic [31:0] rng = 32'h3889_f5bb;
	int cycles = 0;
	string test_name = "reset";
	int rd_errors = 0;
	int tm_errors = 0;
	int wait_errors = 0;
	int vid_errors = 0;

	// Expected values and the flags that arm each check
	logic rd_check = 1'b0;
	logic [7:0] rd_exp = 8'h00;
	logic tm_check = 1'b0;
	logic [7:0] tm_lo = 8'h00;
	logic [7:0] tm_hi = 8'h00;
	logic wait_check = 1'b0;
	logic wait_exp = 1'b0;
	logic vid_check = 1'b0;
	logic [23:0] vid_exp = 24'h0;
	logic vid_check_d = 1'b0;
	logic [23:0] vid_exp_d = 24'h0;
	logic spr_hi_model = 1'b0;

	logic [14:0] rom_addr [16];
	logic [7:0] rom_data [16];
	logic [15:0] ram_addr [16];
	logic [7:0] ram_data [16];

	system #(
		.TICKS_PER_MS(TICKS)
	) uut (
		.clk_24(clk_24), .rst(rst), .pause(pause), .menu(menu),
		.cpu_addr(cpu_addr), .cpu_dout(cpu_dout), .cpu_wr_n(cpu_wr_n),
		.cpu_din(cpu_din), .cpu_wait(cpu_wait),
		.dn_addr(dn_addr), .dn_data(dn_data), .dn_wr(dn_wr), .dn_index(dn_index),
		.joystick(joystick), .paddle(paddle), .timestamp(timestamp),
		.char_rgb(char_rgb), .char_a(char_a), .spr_rgb(spr_rgb), .spr_a(spr_a),
		.tile_rgb(tile_rgb), .tile_a(tile_a),
		.sf_on1(sf_on1), .sf_on2(sf_on2), .sf_on3(sf_on3),
		.sf_star1(sf_star1), .sf_star2(sf_star2), .sf_star3(sf_star3),
		.vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b)
	);

	initial
	begin
		clk_24 = 1'b0;
	end

	always #50 clk_24 = ~clk_24;

	// Mixer output lags its inputs by one clock
	always @(posedge clk_24)
	begin
		vid_check_d <= vid_check;
		vid_exp_d <= vid_exp;
	end

	read_value: assert property (@(posedge clk_24) rd_check |-> cpu_din == rd_exp)
		else
		begin
			rd_errors++;
			$display("Fail %s expected %h actual %h", test_name, $sampled(rd_exp),
				$sampled(cpu_din));
		end

	timer_value: assert property (@(posedge clk_24)
		tm_check |-> (cpu_din >= tm_lo && cpu_din <= tm_hi))
		else
		begin
			tm_errors++;
			$display("Fail %s expected %0d to %0d actual %0d", test_name, $sampled(tm_lo),
				$sampled(tm_hi), $sampled(cpu_din));
		end

	wait_level: assert property (@(posedge clk_24) wait_check |-> cpu_wait == wait_exp)
		else
		begin
			wait_errors++;
			$display("Fail %s expected %b actual %b", test_name, $sampled(wait_exp),
				$sampled(cpu_wait));
		end

	video_value: assert property (@(posedge clk_24)
		vid_check_d |-> {vga_b, vga_g, vga_r} == vid_exp_d)
		else
		begin
			vid_errors++;
			$display("Fail %s expected %h actual %h", test_name, $sampled(vid_exp_d),
				$sampled({vga_b, vga_g, vga_r}));
		end

	always @(posedge clk_24)
	begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES)
		begin
			$display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
			$display("sim failed");
			$finish;
		end
	end

	function automatic logic [31:0] next_rand();
		logic [31:0] s;
		s = rng;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		rng = s;
		return s;
	endfunction

	// Painter's order with the lowest layer first
	function automatic logic [23:0] mix_model(input logic spr_hi,
		input logic [23:0] ch, input logic ch_a, input logic [23:0] sp, input logic sp_a,
		input logic [23:0] tl, input logic tl_a, input logic [2:0] on,
		input logic [7:0] s1, input logic [7:0] s2, input logic [7:0] s3);
		logic [7:0] grey;
		logic [23:0] result;
		if (on[0])
			grey = s1;
		else if (on[1])
			grey = s2 & 8'h7F;
		else if (on[2])
			grey = s3 & 8'h3F;
		else
			grey = 8'h00;
		result = {grey, grey, grey};
		if (tl_a)
			result = tl;
		if (spr_hi)
		begin
			if (ch_a)
				result = ch;
			if (sp_a)
				result = sp;
		end
		else
		begin
			if (sp_a)
				result = sp;
			if (ch_a)
				result = ch;
		end
		return result;
	endfunction

	// All tasks start and end on a falling edge
	task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
		cpu_addr = addr;
		cpu_dout = data;
		cpu_wr_n = 1'b0;
		@(negedge clk_24);
		cpu_wr_n = 1'b1;
		cpu_addr = IDLE_ADDR;
	endtask

	task automatic cpu_read(input logic [15:0] addr, input logic [7:0] exp);
		cpu_addr = addr;
		@(negedge clk_24);
		rd_exp = exp;
		rd_check = 1'b1;
		@(negedge clk_24);
		rd_check = 1'b0;
		cpu_addr = IDLE_ADDR;
	endtask

	task automatic timer_read(input logic [7:0] exp);
		cpu_addr = 16'h8900;
		@(negedge clk_24);
		tm_lo = (exp == 8'd0) ? 8'd0 : exp - 8'd1;
		tm_hi = exp + 8'd1;
		tm_check = 1'b1;
		@(negedge clk_24);
		tm_check = 1'b0;
		cpu_addr = IDLE_ADDR;
	endtask

	task automatic check_wait(input logic exp);
		wait_exp = exp;
		wait_check = 1'b1;
		@(negedge clk_24);
		wait_check = 1'b0;
	endtask

	task automatic download(input logic [14:0] addr, input logic [7:0] data,
		input logic [7:0] index);
		dn_addr = {2'b00, addr};
		dn_data = data;
		dn_index = index;
		dn_wr = 1'b1;
		@(negedge clk_24);
		dn_wr = 1'b0;
	endtask

	task automatic drive_pixel();
		logic [31:0] r1;
		logic [31:0] r2;
		logic [31:0] r3;
		logic [31:0] r4;
		r1 = next_rand();
		r2 = next_rand();
		r3 = next_rand();
		r4 = next_rand();
		char_rgb = r1[23:0];
		char_a = r1[24];
		spr_rgb = r2[23:0];
		spr_a = r2[24];
		tile_rgb = r3[23:0];
		tile_a = r3[24];
		sf_star1 = r4[7:0];
		sf_star2 = r4[15:8];
		sf_star3 = r4[23:16];
		{sf_on3, sf_on2, sf_on1} = r4[26:24];
		vid_exp = mix_model(spr_hi_model, char_rgb, char_a, spr_rgb, spr_a, tile_rgb, tile_a,
			r4[26:24], sf_star1, sf_star2, sf_star3);
		vid_check = 1'b1;
		@(negedge clk_24);
	endtask

	initial
	begin
		logic [31:0] r;
		logic [39:0] ts_ext;
		rst = 1'b1;
		pause = 1'b0;
		menu = 1'b0;
		cpu_addr = IDLE_ADDR;
		cpu_dout = 8'h00;
		cpu_wr_n = 1'b1;
		dn_addr = '0;
		dn_data = 8'h00;
		dn_wr = 1'b0;
		dn_index = 8'h00;
		joystick = '0;
		paddle = '0;
		timestamp = '0;
		char_rgb = '0;
		spr_rgb = '0;
		tile_rgb = '0;
		char_a = 1'b0;
		spr_a = 1'b0;
		tile_a = 1'b0;
		{sf_on3, sf_on2, sf_on1} = 3'b000;
		sf_star1 = 8'h00;
		sf_star2 = 8'h00;
		sf_star3 = 8'h00;
		repeat (4) @(negedge clk_24);
		rst = 1'b0;
		@(negedge clk_24);

		// Index 3 writes aim at the same addresses and must be ignored
		test_name = "pgrom";
		for (int i = 0; i < 16; i++)
		begin
			r = next_rand();
			rom_addr[i] = {i[3:0], r[10:0]};
			rom_data[i] = r[23:16];
			download(rom_addr[i], rom_data[i], 8'd0);
		end
		for (int i = 0; i < 16; i++)
			download(rom_addr[i], ~rom_data[i], 8'd3);
		for (int i = 0; i < 16; i++)
			cpu_read({1'b0, rom_addr[i]}, rom_data[i]);

		test_name = "wkram";
		for (int i = 0; i < 16; i++)
		begin
			r = next_rand();
			ram_addr[i] = {2'b11, i[3:0], r[9:0]};
			ram_data[i] = r[23:16];
			cpu_write(ram_addr[i], ram_data[i]);
		end
		for (int i = 0; i < 16; i++)
			cpu_read(ram_addr[i], ram_data[i]);
		test_name = "unmapped";
		cpu_read(16'h8F80, 8'h00);

		test_name = "inputs";
		joystick = {next_rand(), next_rand(), next_rand(), next_rand(), next_rand(), next_rand()};
		r = next_rand();
		paddle = {next_rand(), r[15:0]};
		timestamp = {r[31], next_rand()};
		ts_ext = {7'b0, timestamp};
		for (int k = 0; k < 24; k++)
			cpu_read({8'h81, k[7:0]}, joystick[k*8 +: 8]);
		for (int k = 0; k < 6; k++)
			cpu_read({8'h84, k[7:0]}, paddle[k*8 +: 8]);
		for (int k = 0; k < 5; k++)
			cpu_read({8'h88, k[7:0]}, ts_ext[k*8 +: 8]);

		test_name = "timer";
		cpu_write(16'h8900, 8'h00);
		repeat (5 * TICKS) @(negedge clk_24);
		timer_read(8'd5);
		cpu_write(16'h8955, 8'h00);
		repeat (20 * TICKS) @(negedge clk_24);
		timer_read(8'd20);
		cpu_read(16'h8901, 8'h00);
		cpu_write(16'h8900, 8'h00);
		timer_read(8'd0);

		test_name = "pause";
		check_wait(1'b0);
		cpu_write(16'h8A30, 8'h00);
		check_wait(1'b1);
		pause = 1'b1;
		check_wait(1'b1);
		pause = 1'b0;
		check_wait(1'b0);

		test_name = "menu";
		cpu_read(16'h8A31, 8'h00);
		menu = 1'b1;
		@(negedge clk_24);
		menu = 1'b0;
		cpu_read(16'h8A31, 8'hFF);
		cpu_write(16'h8A31, 8'h00);
		cpu_read(16'h8A31, 8'h00);

		test_name = "mixer low";
		cpu_write(16'h8001, 8'hFE);
		spr_hi_model = 1'b0;
		repeat (32) drive_pixel();
		vid_check = 1'b0;
		test_name = "mixer high";
		cpu_write(16'h8001, 8'h01);
		spr_hi_model = 1'b1;
		repeat (32) drive_pixel();
		vid_check = 1'b0;
		repeat (3) @(negedge clk_24);

		$display("Errors: read %0d timer %0d wait %0d video %0d", rd_errors, tm_errors,
			wait_errors, vid_errors);
		if (rd_errors + tm_errors + wait_errors + vid_errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

// File: verilog/system.sv
`timescale 1ns/1ps

module system #(
	parameter int PGROM_W = mem_map_pkg::PGROM_W,
	parameter int WKRAM_W = 14,
	parameter int TICKS_PER_MS = 24000
) (
	input  logic clk_24,
	input  logic rst,
	input  logic pause,
	input  logic menu,

	// CPU bus
	input  logic [mem_map_pkg::ADDR_W-1:0] cpu_addr,
	input  logic [mem_map_pkg::DATA_W-1:0] cpu_dout,
	input  logic cpu_wr_n,
	output logic [mem_map_pkg::DATA_W-1:0] cpu_din,
	output logic cpu_wait,

	// ROM download
	input  logic [mem_map_pkg::DN_ADDR_W-1:0] dn_addr,
	input  logic [mem_map_pkg::DATA_W-1:0] dn_data,
	input  logic dn_wr,
	input  logic [mem_map_pkg::DN_INDEX_W-1:0] dn_index,

	// Host inputs
	input  logic [mem_map_pkg::JOYSTICK_W-1:0] joystick,
	input  logic [mem_map_pkg::PADDLE_W-1:0] paddle,
	input  logic [mem_map_pkg::TIMESTAMP_W-1:0] timestamp,

	// Layer pixels
	input  video_pkg::rgb_t char_rgb,
	input  logic char_a,
	input  video_pkg::rgb_t spr_rgb,
	input  logic spr_a,
	input  video_pkg::rgb_t tile_rgb,
	input  logic tile_a,
	input  logic sf_on1,
	input  logic sf_on2,
	input  logic sf_on3,
	input  logic [video_pkg::STAR_W-1:0] sf_star1,
	input  logic [video_pkg::STAR_W-1:0] sf_star2,
	input  logic [video_pkg::STAR_W-1:0] sf_star3,
	output logic [video_pkg::CHAN_W-1:0] vga_r,
	output logic [video_pkg::CHAN_W-1:0] vga_g,
	output logic [video_pkg::CHAN_W-1:0] vga_b
);

	logic pgrom_sel;
	logic wkram_sel;
	logic wkram_wr;
	logic video_ctl_wr;
	logic pause_wr;
	logic menu_wr;
	logic timer_clr;
	logic [mem_map_pkg::DATA_W-1:0] pgrom_q;
	logic [mem_map_pkg::DATA_W-1:0] wkram_q;
	logic [15:0] timer_count;
	logic menu_flag;
	logic sprite_high;

	bus_decode decode (
		.clk_24(clk_24),
		.cpu_addr(cpu_addr),
		.cpu_wr_n(cpu_wr_n),
		.joystick(joystick),
		.paddle(paddle),
		.timestamp(timestamp),
		.pgrom_q(pgrom_q),
		.wkram_q(wkram_q),
		.timer_count(timer_count),
		.menu_flag(menu_flag),
		.pgrom_sel(pgrom_sel),
		.wkram_sel(wkram_sel),
		.wkram_wr(wkram_wr),
		.video_ctl_wr(video_ctl_wr),
		.pause_wr(pause_wr),
		.menu_wr(menu_wr),
		.timer_clr(timer_clr),
		.cpu_din(cpu_din)
	);

	memory_block #(
		.PGROM_W(PGROM_W),
		.WKRAM_W(WKRAM_W)
	) mem (
		.clk_24(clk_24),
		.cpu_addr(cpu_addr),
		.cpu_dout(cpu_dout),
		.pgrom_sel(pgrom_sel),
		.wkram_sel(wkram_sel),
		.wkram_wr(wkram_wr),
		.dn_addr(dn_addr),
		.dn_data(dn_data),
		.dn_wr(dn_wr),
		.dn_index(dn_index),
		.pgrom_q(pgrom_q),
		.wkram_q(wkram_q)
	);

	// Millisecond timer, cleared by any write to its page
	ms_timer #(
		.TICKS_PER_MS(TICKS_PER_MS)
	) timer (
		.clk_24(clk_24),
		.rst(rst),
		.clr(timer_clr),
		.count(timer_count)
	);

	system_control sysctl (
		.clk_24(clk_24),
		.rst(rst),
		.cpu_dout(cpu_dout),
		.video_ctl_wr(video_ctl_wr),
		.pause_wr(pause_wr),
		.menu_wr(menu_wr),
		.pause(pause),
		.menu(menu),
		.sprite_high(sprite_high),
		.cpu_wait(cpu_wait),
		.menu_flag(menu_flag)
	);

	layer_mixer mixer (
		.clk_24(clk_24),
		.sprite_high(sprite_high),
		.char_rgb(char_rgb),
		.char_a(char_a),
		.spr_rgb(spr_rgb),
		.spr_a(spr_a),
		.tile_rgb(tile_rgb),
		.tile_a(tile_a),
		.sf_on1(sf_on1),
		.sf_on2(sf_on2),
		.sf_on3(sf_on3),
		.sf_star1(sf_star1),
		.sf_star2(sf_star2),
		.sf_star3(sf_star3),
		.vga_r(vga_r),
		.vga_g(vga_g),
		.vga_b(vga_b)
	);

endmodule

// File: verilog/layer_mixer.sv
`timescale 1ns/1ps

module layer_mixer (
	input  logic clk_24,
	input  logic sprite_high,
	input  video_pkg::rgb_t char_rgb,
	input  logic char_a,
	input  video_pkg::rgb_t spr_rgb,
	input  logic spr_a,
	input  video_pkg::rgb_t tile_rgb,
	input  logic tile_a,
	input  logic sf_on1,
	input  logic sf_on2,
	input  logic sf_on3,
	input  logic [video_pkg::STAR_W-1:0] sf_star1,
	input  logic [video_pkg::STAR_W-1:0] sf_star2,
	input  logic [video_pkg::STAR_W-1:0] sf_star3,
	output logic [video_pkg::CHAN_W-1:0] vga_r,
	output logic [video_pkg::CHAN_W-1:0] vga_g,
	output logic [video_pkg::CHAN_W-1:0] vga_b
);

	logic [video_pkg::STAR_W-1:0] star_col;
	video_pkg::rgb_t star_rgb;
	video_pkg::rgb_t mix_rgb;
	video_pkg::rgb_t rgb_q;

	// Nearest starfield wins, the further ones lose brightness bits
	assign star_col = sf_on1 ? sf_star1 :
		sf_on2 ? {{(video_pkg::STAR_W-video_pkg::STAR2_W){1'b0}},
			sf_star2[video_pkg::STAR2_W-1:0]} :
		sf_on3 ? {{(video_pkg::STAR_W-video_pkg::STAR3_W){1'b0}},
			sf_star3[video_pkg::STAR3_W-1:0]} :
		'0;

	// Stars are grey, black background when none is lit
	assign star_rgb = {3{star_col}};

	always_comb
	begin
		if (sprite_high)
		begin
			if (spr_a)
				mix_rgb = spr_rgb;
			else if (char_a)
				mix_rgb = char_rgb;
			else if (tile_a)
				mix_rgb = tile_rgb;
			else
				mix_rgb = star_rgb;
		end
		else
		begin
			if (char_a)
				mix_rgb = char_rgb;
			else if (spr_a)
				mix_rgb = spr_rgb;
			else if (tile_a)
				mix_rgb = tile_rgb;
			else
				mix_rgb = star_rgb;
		end
	end

	always_ff @(posedge clk_24)
	begin
		rgb_q <= mix_rgb;
	end

	assign vga_r = rgb_q.r;
	assign vga_g = rgb_q.g;
	assign vga_b = rgb_q.b;

endmodule

// File: verilog/system_control.sv
`timescale 1ns/1ps

module system_control (
	input  logic clk_24,
	input  logic rst,
	input  logic [mem_map_pkg::DATA_W-1:0] cpu_dout,
	input  logic video_ctl_wr,
	input  logic pause_wr,
	input  logic menu_wr,
	input  logic pause,
	input  logic menu,
	output logic sprite_high,
	output logic cpu_wait,
	output logic menu_flag
);

	logic [mem_map_pkg::DATA_W-1:0] video_ctl;
	logic pause_trig;

	always_ff @(posedge clk_24)
	begin
		if (rst)
		begin
			video_ctl <= '0;
			pause_trig <= 1'b0;
			menu_flag <= 1'b0;
		end
		else
		begin
			if (video_ctl_wr)
				video_ctl <= cpu_dout;

			// External pause releases the CPU pause request
			if (pause)
				pause_trig <= 1'b0;
			else if (pause_wr)
				pause_trig <= 1'b1;

			// CPU acknowledges the menu request by writing to it
			if (menu_wr)
				menu_flag <= 1'b0;
			else if (menu)
				menu_flag <= 1'b1;
		end
	end

	assign sprite_high = video_ctl[video_pkg::CTL_SPRITE_HIGH];
	assign cpu_wait = pause || pause_trig;

	// A pause write keeps the CPU waiting until the external pause shows up
	pause_held: assert property (@(posedge clk_24) disable iff (rst)
		(pause_wr && !pause) |=> (cpu_wait until pause))
		else $error("cpu_wait dropped before the external pause");

endmodule

// File: verilog/ms_timer.sv
`timescale 1ns/1ps

module ms_timer #(
	parameter int TICKS_PER_MS = 24000
) (
	input  logic clk_24,
	input  logic rst,
	input  logic clr,
	output logic [15:0] count
);

	localparam int PRE_W = (TICKS_PER_MS > 1) ? $clog2(TICKS_PER_MS) : 1;
	localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(TICKS_PER_MS - 1);

	logic [PRE_W-1:0] prescale;
	logic tick;

	// One tick per millisecond of clk_24
	assign tick = prescale == PRE_LAST;

	always_ff @(posedge clk_24)
	begin
		if (rst || clr)
		begin
			prescale <= '0;
			count <= '0;
		end
		else if (tick)
		begin
			prescale <= '0;
			// Wraps at 16 bits
			count <= count + 16'd1;
		end
		else
		begin
			prescale <= prescale + 1'b1;
		end
	end

endmodule

// File: verilog/memory_block.sv
`timescale 1ns/1ps

module memory_block #(
	parameter int PGROM_W = 15,
	parameter int WKRAM_W = 14
) (
	input  logic clk_24,
	input  logic [mem_map_pkg::ADDR_W-1:0] cpu_addr,
	input  logic [mem_map_pkg::DATA_W-1:0] cpu_dout,
	input  logic pgrom_sel,
	input  logic wkram_sel,
	input  logic wkram_wr,
	input  logic [mem_map_pkg::DN_ADDR_W-1:0] dn_addr,
	input  logic [mem_map_pkg::DATA_W-1:0] dn_data,
	input  logic dn_wr,
	input  logic [mem_map_pkg::DN_INDEX_W-1:0] dn_index,
	output logic [mem_map_pkg::DATA_W-1:0] pgrom_q,
	output logic [mem_map_pkg::DATA_W-1:0] wkram_q
);

	logic [mem_map_pkg::DATA_W-1:0] pgrom [0:(1 << PGROM_W)-1];
	logic [mem_map_pkg::DATA_W-1:0] wkram [0:(1 << WKRAM_W)-1];
	logic pgrom_wr;

	// Only download index 0 targets the program ROM
	assign pgrom_wr = dn_wr && (dn_index == mem_map_pkg::PGROM_DN_INDEX);

	// Program ROM, download side writes
	always_ff @(posedge clk_24)
	begin
		if (pgrom_wr)
			pgrom[dn_addr[PGROM_W-1:0]] <= dn_data;
	end

	// Program ROM, CPU side reads
	always_ff @(posedge clk_24)
	begin
		if (pgrom_sel)
			pgrom_q <= pgrom[cpu_addr[PGROM_W-1:0]];
	end

	// Work RAM, single port with read-before-write
	always_ff @(posedge clk_24)
	begin
		if (wkram_wr)
			wkram[cpu_addr[WKRAM_W-1:0]] <= cpu_dout;
		if (wkram_sel)
			wkram_q <= wkram[cpu_addr[WKRAM_W-1:0]];
	end

	// The RAM only keeps the low address bits, so a stray strobe would alias
	wkram_in_region: assert property (@(posedge clk_24)
		wkram_wr |-> cpu_addr[mem_map_pkg::ADDR_W-1 -: 2] == mem_map_pkg::WKRAM_BASE_TOP)
		else $error("work RAM write outside work RAM at %h", cpu_addr);

endmodule

// File: verilog/bus_decode.sv
`timescale 1ns/1ps

module bus_decode (
	input  logic clk_24,
	input  logic [mem_map_pkg::ADDR_W-1:0] cpu_addr,
	input  logic cpu_wr_n,
	input  logic [mem_map_pkg::JOYSTICK_W-1:0] joystick,
	input  logic [mem_map_pkg::PADDLE_W-1:0] paddle,
	input  logic [mem_map_pkg::TIMESTAMP_W-1:0] timestamp,
	input  logic [mem_map_pkg::DATA_W-1:0] pgrom_q,
	input  logic [mem_map_pkg::DATA_W-1:0] wkram_q,
	input  logic [15:0] timer_count,
	input  logic menu_flag,
	output logic pgrom_sel,
	output logic wkram_sel,
	output logic wkram_wr,
	output logic video_ctl_wr,
	output logic pause_wr,
	output logic menu_wr,
	output logic timer_clr,
	output logic [mem_map_pkg::DATA_W-1:0] cpu_din
);

	logic cpu_wr;
	logic [7:0] page;
	logic joystick_sel;
	logic paddle_sel;
	logic timestamp_sel;
	logic timer_sel;
	logic video_ctl_sel;
	logic pause_sel;
	logic menu_sel;

	// Inputs padded out to a whole number of addressable bytes
	logic [32*8-1:0] joystick_ext;
	logic [8*8-1:0] paddle_ext;
	logic [8*8-1:0] timestamp_ext;

	logic [mem_map_pkg::DATA_W-1:0] io_byte;
	logic [mem_map_pkg::DATA_W-1:0] io_q;
	logic rd_pgrom;
	logic rd_wkram;

	assign cpu_wr = !cpu_wr_n;
	assign page = cpu_addr[mem_map_pkg::ADDR_W-1 -: 8];

	assign pgrom_sel = cpu_addr[mem_map_pkg::ADDR_W-1:mem_map_pkg::PGROM_W] == '0;
	assign wkram_sel = cpu_addr[mem_map_pkg::ADDR_W-1 -: 2] == mem_map_pkg::WKRAM_BASE_TOP;
	assign joystick_sel = page == mem_map_pkg::JOYSTICK_PAGE;
	assign paddle_sel = page == mem_map_pkg::PADDLE_PAGE;
	assign timestamp_sel = page == mem_map_pkg::TIMESTAMP_PAGE;
	assign timer_sel = page == mem_map_pkg::TIMER_PAGE;
	assign video_ctl_sel = cpu_addr == mem_map_pkg::VIDEO_CTL_ADDR;
	assign pause_sel = cpu_addr == mem_map_pkg::PAUSE_ADDR;
	assign menu_sel = cpu_addr == mem_map_pkg::MENU_ADDR;

	// Finished write strobes for the receivers
	assign wkram_wr = cpu_wr && wkram_sel;
	assign video_ctl_wr = cpu_wr && video_ctl_sel;
	assign pause_wr = cpu_wr && pause_sel;
	assign menu_wr = cpu_wr && menu_sel;
	assign timer_clr = cpu_wr && timer_sel;

	assign joystick_ext = {{(32*8-mem_map_pkg::JOYSTICK_W){1'b0}}, joystick};
	assign paddle_ext = {{(8*8-mem_map_pkg::PADDLE_W){1'b0}}, paddle};
	assign timestamp_ext = {{(8*8-mem_map_pkg::TIMESTAMP_W){1'b0}}, timestamp};

	// Readback byte, low address bits pick the byte within the input vector
	always_comb
	begin
		if (joystick_sel)
			io_byte = joystick_ext[{cpu_addr[4:0], 3'd0} +: 8];
		else if (paddle_sel)
			io_byte = paddle_ext[{cpu_addr[2:0], 3'd0} +: 8];
		else if (timestamp_sel)
			io_byte = timestamp_ext[{cpu_addr[2:0], 3'd0} +: 8];
		else if (timer_sel)
			io_byte = cpu_addr[0] ? timer_count[15:8] : timer_count[7:0];
		else if (menu_sel)
			io_byte = {mem_map_pkg::DATA_W{menu_flag}};
		else
			io_byte = '0;
	end

	// Match the one clock latency of the ROM and RAM reads
	always_ff @(posedge clk_24)
	begin
		rd_pgrom <= pgrom_sel;
		rd_wkram <= wkram_sel;
		io_q <= io_byte;
	end

	assign cpu_din = rd_pgrom ? pgrom_q :
		rd_wkram ? wkram_q :
		io_q;

	// No two regions may ever claim the same address
	region_onehot: assert property (@(posedge clk_24)
		!$isunknown(cpu_addr) |-> $onehot0({pgrom_sel, wkram_sel, joystick_sel, paddle_sel,
			timestamp_sel, timer_sel, video_ctl_sel, pause_sel, menu_sel}))
		else $error("overlapping region selects at address %h", cpu_addr);

endmodule

// File: verilog/video_pkg.sv
package video_pkg;

	// Width of one colour channel
	localparam int CHAN_W = 8;

	// One pixel, blue in the top byte and red in the bottom byte
	typedef struct packed {
		logic [CHAN_W-1:0] b;
		logic [CHAN_W-1:0] g;
		logic [CHAN_W-1:0] r;
	} rgb_t;

	// Star brightness from each starfield layer
	localparam int STAR_W = 8;

	// Layers 2 and 3 are dimmer, so fewer brightness bits survive
	localparam int STAR2_W = STAR_W - 1;
	localparam int STAR3_W = STAR_W - 2;

	// Video control register bits
	// Sprites drawn above the charmap when set
	localparam int CTL_SPRITE_HIGH = 0;

endpackage

// File: verilog/mem_map_pkg.sv
package mem_map_pkg;

	// CPU bus widths
	localparam int ADDR_W = 16;
	localparam int DATA_W = 8;

	// Download port
	localparam int DN_ADDR_W = 17;
	localparam int DN_INDEX_W = 8;
	localparam logic [DN_INDEX_W-1:0] PGROM_DN_INDEX = 8'd0;

	// Program ROM covers 0x0000 - 0x7FFF
	localparam int PGROM_W = 15;

	// Work RAM lives in the top quarter, 0xC000 - 0xFFFF
	localparam logic [1:0] WKRAM_BASE_TOP = 2'b11;

	// Single address registers
	localparam logic [ADDR_W-1:0] VIDEO_CTL_ADDR = 16'h8001;
	localparam logic [ADDR_W-1:0] PAUSE_ADDR = 16'h8A30;
	localparam logic [ADDR_W-1:0] MENU_ADDR = 16'h8A31;

	// 256 byte pages, matched on the high address byte
	localparam logic [7:0] JOYSTICK_PAGE = 8'h81;
	localparam logic [7:0] PADDLE_PAGE = 8'h84;
	localparam logic [7:0] TIMESTAMP_PAGE = 8'h88;
	localparam logic [7:0] TIMER_PAGE = 8'h89;

	// Input vectors read back one byte at a time
	// 6 pads with 32 buttons each
	localparam int JOYSTICK_W = 192;
	// 6 paddles, 8 bits each
	localparam int PADDLE_W = 48;
	// Seconds count plus a toggle bit on top
	localparam int TIMESTAMP_W = 33;

endpackage
